// File: Bender.yml
package:
  name: lsu_subsys

sources:
  - files:
      - design/rv_lsu_isa_pkg.sv
      - design/lsu_mem_pkg.sv
      - design/data_mem_if.sv
      - design/lsu_control.sv
      - design/byte_lane_decoder.sv
      - design/load_extractor.sv
      - design/data_ram.sv
      - design/lsu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/lsu_tb.sv

// File: design/byte_lane_decoder.sv
// Halfword lanes follow offset[1] only; size code 3 enables no lanes
`timescale 1ns/10ps
`default_nettype none

module byte_lane_decoder (
    input  wire rv_lsu_isa_pkg::access_size_t size,
    input  wire lsu_mem_pkg::byte_off_t      offset,
    input  wire lsu_mem_pkg::word_t          store_data,
    output lsu_mem_pkg::byte_en_t            byte_en,
    output lsu_mem_pkg::word_t               wdata
);

    always_comb
    begin
        byte_en = '0;
        wdata   = store_data;
        case (size)
            rv_lsu_isa_pkg::SIZE_B:
            begin
                byte_en[offset] = 1'b1;
                wdata = {4{store_data[7:0]}};    // Same byte in every lane
            end
            rv_lsu_isa_pkg::SIZE_H:
            begin
                byte_en = offset[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{store_data[15:0]}};
            end
            rv_lsu_isa_pkg::SIZE_W:
            begin
                byte_en = '1;
            end
            default:
            begin
                byte_en = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/data_mem_if.sv
// Strobes are single cycle and never both high; rdata is valid the cycle after read_en
`timescale 1ns/10ps
`default_nettype none

interface data_mem_if;

    lsu_mem_pkg::word_index_t word_index;
    logic                     read_en;
    logic                     write_en;
    lsu_mem_pkg::byte_en_t    byte_en;
    lsu_mem_pkg::word_t       wdata;
    lsu_mem_pkg::word_t       rdata;   // Held until the next read

    modport ctrl (
        output word_index, read_en, write_en, byte_en, wdata,
        input  rdata
    );

    modport ram (
        input  word_index, read_en, write_en, byte_en, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/data_ram.sv
// 256 x 32 single-port RAM, contents undefined after reset, one-cycle registered read
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input wire        memory_done,
    data_mem_if.ram   mem
);

    lsu_mem_pkg::word_t mem_array [lsu_mem_pkg::MEM_WORDS];
    lsu_mem_pkg::word_t rdata_q;

    // Per-lane write
    always_ff @(posedge memory_done)
    begin
        if (mem.write_en)
        begin
            for (int lane = 0; lane < lsu_mem_pkg::BYTE_LANES; lane++)
            begin
                if (mem.byte_en[lane])
                    mem_array[mem.word_index][lane*8 +: 8] <= mem.wdata[lane*8 +: 8];
            end
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge memory_done)
    begin
        if (mem.read_en)
            rdata_q <= mem_array[mem.word_index];
    end

    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/load_extractor.sv
// Halfword select ignores offset[0]; load_data only changes on capture
`timescale 1ns/10ps
`default_nettype none

module load_extractor (
    input  wire                               memory_done,
    input  wire                               rst_n,
    input  wire                               capture,
    input  wire rv_lsu_isa_pkg::access_size_t size,
    input  wire lsu_mem_pkg::byte_off_t      offset,
    input  wire                               is_unsigned,
    input  wire lsu_mem_pkg::word_t          rdata,
    output lsu_mem_pkg::word_t               load_data
);

    lsu_mem_pkg::byte_off_t shift_lanes;
    lsu_mem_pkg::word_t     shifted;
    lsu_mem_pkg::word_t     extended;

    // Halfwords are aligned down to lane 0 or lane 2
    assign shift_lanes = (size == rv_lsu_isa_pkg::SIZE_H) ? {offset[1], 1'b0} : offset;
    assign shifted     = rdata >> {shift_lanes, 3'b000};

    always_comb
    begin
        case (size)
            rv_lsu_isa_pkg::SIZE_B:
                extended = {{24{shifted[7] & !is_unsigned}}, shifted[7:0]};
            rv_lsu_isa_pkg::SIZE_H:
                extended = {{16{shifted[15] & !is_unsigned}}, shifted[15:0]};
            default:
                extended = rdata;   // Full word
        endcase
    end

    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
            load_data <= '0;
        else if (capture)
            load_data <= extended;
    end

endmodule

`default_nettype wire

// File: design/lsu_control.sv
// Fixed 3-cycle latency, one access in flight; enable is ignored while busy, misalignment is not trapped
`timescale 1ns/10ps
`default_nettype none

module lsu_control (
    input  wire                         memory_done,
    input  wire                         rst_n,
    input  wire                         enable,
    input  wire rv_lsu_isa_pkg::opcode_t opcode,
    input  wire rv_lsu_isa_pkg::funct3_t funct3,
    input  wire lsu_mem_pkg::addr_t     address,
    input  wire lsu_mem_pkg::word_t     store_data,
    input  wire lsu_mem_pkg::byte_en_t  lane_byte_en,
    input  wire lsu_mem_pkg::word_t     lane_wdata,
    output rv_lsu_isa_pkg::access_size_t req_size,
    output lsu_mem_pkg::byte_off_t      req_offset,
    output lsu_mem_pkg::word_t          req_store_data,
    output logic                        req_unsigned,
    output logic                        capture,
    output logic                        busy,
    output logic                        done,
    output logic                        access_fault,
    data_mem_if.ctrl                    mem
);

    lsu_mem_pkg::lsu_state_t      state;
    lsu_mem_pkg::lsu_state_t      state_next;
    lsu_mem_pkg::word_index_t     index_q;
    rv_lsu_isa_pkg::access_size_t dec_size;
    logic                         dec_unsigned;
    logic                         dec_valid;
    logic                         dec_store;
    logic                         is_store_q;
    logic                         fault_q;
    logic                         accept;

    // Opcode/funct3 decode of the incoming request
    always_comb
    begin
        dec_size     = rv_lsu_isa_pkg::SIZE_W;
        dec_unsigned = 1'b0;
        dec_valid    = 1'b0;
        dec_store    = (opcode == rv_lsu_isa_pkg::OPC_STORE);
        if (opcode == rv_lsu_isa_pkg::OPC_LOAD || dec_store)
        begin
            case (funct3)
                rv_lsu_isa_pkg::F3_B:
                begin
                    dec_size  = rv_lsu_isa_pkg::SIZE_B;
                    dec_valid = 1'b1;
                end
                rv_lsu_isa_pkg::F3_H:
                begin
                    dec_size  = rv_lsu_isa_pkg::SIZE_H;
                    dec_valid = 1'b1;
                end
                rv_lsu_isa_pkg::F3_W:
                begin
                    dec_size  = rv_lsu_isa_pkg::SIZE_W;
                    dec_valid = 1'b1;
                end
                rv_lsu_isa_pkg::F3_BU:
                begin
                    dec_size     = rv_lsu_isa_pkg::SIZE_B;
                    dec_unsigned = 1'b1;
                    dec_valid    = !dec_store;   // No unsigned stores
                end
                rv_lsu_isa_pkg::F3_HU:
                begin
                    dec_size     = rv_lsu_isa_pkg::SIZE_H;
                    dec_unsigned = 1'b1;
                    dec_valid    = !dec_store;
                end
                default:
                begin
                    dec_valid = 1'b0;
                end
            endcase
        end
    end

    assign accept = enable &&
                    (state == lsu_mem_pkg::ST_IDLE || state == lsu_mem_pkg::ST_FINISH);

    always_comb
    begin
        case (state)
            lsu_mem_pkg::ST_IDLE:     state_next = accept ? lsu_mem_pkg::ST_ACCESS
                                                          : lsu_mem_pkg::ST_IDLE;
            lsu_mem_pkg::ST_ACCESS:   state_next = lsu_mem_pkg::ST_READBACK;
            lsu_mem_pkg::ST_READBACK: state_next = lsu_mem_pkg::ST_FINISH;
            default:                  state_next = accept ? lsu_mem_pkg::ST_ACCESS
                                                          : lsu_mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
        begin
            state      <= lsu_mem_pkg::ST_IDLE;
            fault_q    <= 1'b0;
            is_store_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (accept)
            begin
                fault_q    <= !dec_valid;
                is_store_q <= dec_store;
            end
        end
    end

    // Request payload captured on accept
    always_ff @(posedge memory_done)
    begin
        if (accept)
        begin
            req_size       <= dec_size;
            req_unsigned   <= dec_unsigned;
            req_offset     <= address[1:0];
            req_store_data <= store_data;
            index_q        <= address[2 +: lsu_mem_pkg::INDEX_W];
        end
    end

    assign mem.word_index = index_q;
    assign mem.byte_en    = lane_byte_en;
    assign mem.wdata      = lane_wdata;
    assign mem.read_en    = (state == lsu_mem_pkg::ST_ACCESS) && !fault_q && !is_store_q;
    assign mem.write_en   = (state == lsu_mem_pkg::ST_ACCESS) && !fault_q && is_store_q;

    assign capture      = (state == lsu_mem_pkg::ST_READBACK) && !fault_q && !is_store_q;
    assign busy         = (state == lsu_mem_pkg::ST_ACCESS) || (state == lsu_mem_pkg::ST_READBACK);
    assign done         = (state == lsu_mem_pkg::ST_FINISH);
    assign access_fault = done && fault_q;   // Only with done

endmodule

`default_nettype wire

// File: design/lsu_mem_pkg.sv
// 1 KiB word RAM, little-endian lanes; address bits above bit 9 are dropped by the word index
`default_nettype none

package lsu_mem_pkg;

    localparam int WORD_W     = 32;
    localparam int BYTE_LANES = WORD_W / 8;
    localparam int MEM_WORDS  = 256;
    localparam int INDEX_W    = $clog2(MEM_WORDS);

    typedef logic [WORD_W-1:0]             word_t;
    typedef logic [WORD_W-1:0]             addr_t;
    typedef logic [BYTE_LANES-1:0]         byte_en_t;   // Bit n is byte n
    typedef logic [$clog2(BYTE_LANES)-1:0] byte_off_t;
    typedef logic [INDEX_W-1:0]            word_index_t;  // address[9:2]

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_READBACK,
        ST_FINISH
    } lsu_state_t;

endpackage

`default_nettype wire

// File: design/lsu_top.sv
// Load/store unit with 1 KiB data RAM; done follows an accepted enable by exactly 3 cycles
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  wire                          memory_done,
    input  wire                          rst_n,
    input  wire                          enable,
    input  wire rv_lsu_isa_pkg::opcode_t opcode,
    input  wire rv_lsu_isa_pkg::funct3_t funct3,
    input  wire lsu_mem_pkg::addr_t      address,
    input  wire lsu_mem_pkg::word_t      store_data,
    output lsu_mem_pkg::word_t           load_data,
    output logic                         busy,
    output logic                         done,
    output logic                         access_fault
);

    rv_lsu_isa_pkg::access_size_t req_size;
    lsu_mem_pkg::byte_off_t       req_offset;
    lsu_mem_pkg::word_t           req_store_data;
    logic                         req_unsigned;
    logic                         capture;
    lsu_mem_pkg::byte_en_t        lane_byte_en;
    lsu_mem_pkg::word_t           lane_wdata;

    data_mem_if mem_bus ();

    lsu_control i_control (
        .memory_done    (memory_done),
        .rst_n          (rst_n),
        .enable         (enable),
        .opcode         (opcode),
        .funct3         (funct3),
        .address        (address),
        .store_data     (store_data),
        .lane_byte_en   (lane_byte_en),
        .lane_wdata     (lane_wdata),
        .req_size       (req_size),
        .req_offset     (req_offset),
        .req_store_data (req_store_data),
        .req_unsigned   (req_unsigned),
        .capture        (capture),
        .busy           (busy),
        .done           (done),
        .access_fault   (access_fault),
        .mem            (mem_bus.ctrl)
    );

    byte_lane_decoder i_lanes (
        .size       (req_size),
        .offset     (req_offset),
        .store_data (req_store_data),
        .byte_en    (lane_byte_en),
        .wdata      (lane_wdata)
    );

    load_extractor i_extract (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .capture     (capture),
        .size        (req_size),
        .offset      (req_offset),
        .is_unsigned (req_unsigned),
        .rdata       (mem_bus.rdata),
        .load_data   (load_data)
    );

    data_ram i_ram (
        .memory_done (memory_done),
        .mem         (mem_bus.ram)
    );

endmodule

`default_nettype wire

// File: design/rv_lsu_isa_pkg.sv
// RV32I load/store encodings only; funct3 values outside the five load and three store forms are unsupported
`default_nettype none

package rv_lsu_isa_pkg;

    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int SIZE_W_BITS = 2;

    typedef logic [OPCODE_W-1:0]    opcode_t;
    typedef logic [FUNCT3_W-1:0]    funct3_t;
    typedef logic [SIZE_W_BITS-1:0] access_size_t;

    // Major opcodes
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // funct3 for loads and stores
    localparam funct3_t F3_B  = 3'd0;  // LB / SB
    localparam funct3_t F3_H  = 3'd1;  // LH / SH
    localparam funct3_t F3_W  = 3'd2;  // LW / SW
    localparam funct3_t F3_BU = 3'd4;  // Loads only
    localparam funct3_t F3_HU = 3'd5;  // Loads only

    // Access width code with value 3 unused
    localparam access_size_t SIZE_B = 2'd0;
    localparam access_size_t SIZE_H = 2'd1;
    localparam access_size_t SIZE_W = 2'd2;

endpackage

`default_nettype wire

// File: lsu_subsys.f
+incdir+tests
design/rv_lsu_isa_pkg.sv
design/lsu_mem_pkg.sv
design/data_mem_if.sv
design/lsu_control.sv
design/byte_lane_decoder.sv
design/load_extractor.sv
design/data_ram.sv
design/lsu_top.sv
tests/lsu_tb.sv

// File: tests/lsu_ref_model.svh
// Included inside lsu_tb only; byte model of the 1 KiB RAM, address bits above bit 9 are dropped
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

logic [7:0]  model_mem [1024];
logic [15:0] lfsr_state = 16'd46763;

// x^16 + x^14 + x^13 + x^11 + 1 with one new bit per step
function automatic logic lfsr_step();
    logic fb;
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
        value = {value[30:0], lfsr_step()};
    return value;
endfunction

// The eight RV32I loads and stores
function automatic logic instr_supported(input rv_lsu_isa_pkg::opcode_t op,
                                         input rv_lsu_isa_pkg::funct3_t f3);
    if (op == rv_lsu_isa_pkg::OPC_LOAD)
        return (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
    if (op == rv_lsu_isa_pkg::OPC_STORE)
        return (f3 <= 3'd2);
    return 1'b0;
endfunction

// First byte touched; halfwords drop bit 0, words drop bits 1:0
function automatic int base_byte(input lsu_mem_pkg::addr_t addr,
                                 input rv_lsu_isa_pkg::funct3_t f3);
    case (f3[1:0])
        2'd0:    return int'(addr[9:0]);
        2'd1:    return int'({addr[9:1], 1'b0});
        default: return int'({addr[9:2], 2'b00});
    endcase
endfunction

function automatic int access_bytes(input rv_lsu_isa_pkg::funct3_t f3);
    return 1 << f3[1:0];   // 1, 2 or 4
endfunction

function automatic void model_store(input lsu_mem_pkg::addr_t addr,
                                    input rv_lsu_isa_pkg::funct3_t f3,
                                    input lsu_mem_pkg::word_t data);
    int base;
    base = base_byte(addr, f3);
    for (int i = 0; i < access_bytes(f3); i++)
        model_mem[base + i] = data[i*8 +: 8];   // Low bytes first
endfunction

function automatic lsu_mem_pkg::word_t model_load(input lsu_mem_pkg::addr_t addr,
                                                  input rv_lsu_isa_pkg::funct3_t f3);
    lsu_mem_pkg::word_t value;
    int                 base;
    int                 count;
    base  = base_byte(addr, f3);
    count = access_bytes(f3);
    value = '0;
    for (int i = 0; i < count; i++)
        value[i*8 +: 8] = model_mem[base + i];
    // Signed forms copy the top loaded bit upward
    if (!f3[2] && count < 4 && value[count*8 - 1])
        value = value | (32'hffff_ffff << (count * 8));
    return value;
endfunction

`endif

// File: tests/lsu_tb.sv
// Self-checking testbench for lsu_top; stops at the first mismatch, RAM contents come from a full SW sweep
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RANDOM_OPS   = 600;
    localparam int FAULT_OPS    = 40;
    localparam int TOTAL_REQ    = 2 * lsu_mem_pkg::MEM_WORDS + RANDOM_OPS + 2 * FAULT_OPS + 8;
    localparam int DONE_LATENCY = 3;
    localparam int WAIT_LIMIT   = 10;

    logic                    memory_done;
    logic                    rst_n;
    logic                    enable;
    rv_lsu_isa_pkg::opcode_t opcode;
    rv_lsu_isa_pkg::funct3_t funct3;
    lsu_mem_pkg::addr_t      address;
    lsu_mem_pkg::word_t      store_data;
    lsu_mem_pkg::word_t      load_data;
    logic                    busy;
    logic                    done;
    logic                    access_fault;
    lsu_mem_pkg::word_t      last_load;   // Expected load_data

    `include "lsu_ref_model.svh"

    lsu_top i_dut (
        .memory_done  (memory_done),
        .rst_n        (rst_n),
        .enable       (enable),
        .opcode       (opcode),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .load_data    (load_data),
        .busy         (busy),
        .done         (done),
        .access_fault (access_fault)
    );

    always #(CLK_PERIOD / 2) memory_done = ~memory_done;

    task automatic check_value(input string name, input lsu_mem_pkg::word_t expected,
                               input lsu_mem_pkg::word_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    // Call on a rising edge
    task automatic drive_request(input rv_lsu_isa_pkg::opcode_t op,
                                 input rv_lsu_isa_pkg::funct3_t f3,
                                 input lsu_mem_pkg::addr_t addr, input lsu_mem_pkg::word_t data);
        enable     <= 1'b1;
        opcode     <= op;
        funct3     <= f3;
        address    <= addr;
        store_data <= data;
    endtask

    // Drops enable, then counts cycles up to done; returns at the falling edge of the done cycle
    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge memory_done);
            enable <= 1'b0;
            cycles++;
            @(negedge memory_done);
            if (cycles > WAIT_LIMIT)
                fail_run({name, ": done did not arrive after the request"});
            if (!done)
                check_value({name, " busy"}, 1, busy);
        end
        while (!done);
        check_value({name, " latency"}, DONE_LATENCY, cycles);
        check_value({name, " busy at done"}, 0, busy);
    endtask

    task automatic do_request(input string name, input rv_lsu_isa_pkg::opcode_t op,
                              input rv_lsu_isa_pkg::funct3_t f3,
                              input lsu_mem_pkg::addr_t addr, input lsu_mem_pkg::word_t data);
        logic supported;
        supported = instr_supported(op, f3);
        if (supported && op == rv_lsu_isa_pkg::OPC_LOAD)
            last_load = model_load(addr, f3);
        else if (supported)
            model_store(addr, f3, data);
        @(posedge memory_done);
        drive_request(op, f3, addr, data);
        wait_done(name);
        check_value({name, " access_fault"}, !supported, access_fault);
        check_value({name, " load_data"}, last_load, load_data);   // Stores and faults keep it
    endtask

    // Enable held through busy, then a new request in the done cycle
    task automatic busy_overlap_test();
        lsu_mem_pkg::addr_t first_addr;
        lsu_mem_pkg::addr_t ignored_addr;
        lsu_mem_pkg::word_t first_data;
        first_addr   = rand_bits(8) << 2;
        ignored_addr = first_addr ^ 32'h0000_0200;   // Another word
        first_data   = rand_bits(32);
        model_store(first_addr, rv_lsu_isa_pkg::F3_W, first_data);
        @(posedge memory_done);
        drive_request(rv_lsu_isa_pkg::OPC_STORE, rv_lsu_isa_pkg::F3_W, first_addr, first_data);
        repeat (2)
        begin
            @(posedge memory_done);
            drive_request(rv_lsu_isa_pkg::OPC_STORE, rv_lsu_isa_pkg::F3_W, ignored_addr,
                          ~first_data);
        end
        @(posedge memory_done);
        drive_request(rv_lsu_isa_pkg::OPC_LOAD, rv_lsu_isa_pkg::F3_W, first_addr, 32'd0);
        @(negedge memory_done);
        check_value("overlap first done", 1, done);
        check_value("overlap first access_fault", 0, access_fault);
        last_load = model_load(first_addr, rv_lsu_isa_pkg::F3_W);
        wait_done("overlap second");
        check_value("overlap load_data", last_load, load_data);
        do_request("overlap ignored word", rv_lsu_isa_pkg::OPC_LOAD, rv_lsu_isa_pkg::F3_W,
                   ignored_addr, 32'd0);
    endtask

    initial
    begin
        #((TOTAL_REQ * 4 + 200) * CLK_PERIOD);
        fail_run("Watchdog timeout: the tests did not finish in the expected time");
    end

    initial
    begin
        lsu_mem_pkg::addr_t      addr;
        rv_lsu_isa_pkg::opcode_t op;
        rv_lsu_isa_pkg::funct3_t f3;
        int                      idx;
        memory_done = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        opcode      = '0;
        funct3      = '0;
        address     = '0;
        store_data  = '0;
        last_load   = '0;
        repeat (2) @(posedge memory_done);
        rst_n <= 1'b1;
        @(negedge memory_done);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset access_fault", 0, access_fault);
        check_value("reset load_data", 0, load_data);

        for (int w = 0; w < lsu_mem_pkg::MEM_WORDS; w++)
            do_request("fill SW", rv_lsu_isa_pkg::OPC_STORE, rv_lsu_isa_pkg::F3_W, w * 4,
                       rand_bits(32));
        for (int w = 0; w < lsu_mem_pkg::MEM_WORDS; w++)
            do_request("readback LW", rv_lsu_isa_pkg::OPC_LOAD, rv_lsu_isa_pkg::F3_W, w * 4,
                       32'd0);

        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            if (rand_bits(1))
            begin
                op = rv_lsu_isa_pkg::OPC_STORE;
                f3 = rand_bits(2) % 3;
            end
            else
            begin
                op  = rv_lsu_isa_pkg::OPC_LOAD;
                idx = rand_bits(3) % 5;
                f3  = (idx < 3) ? idx : idx + 1;   // Skip funct3 3
            end
            addr = rand_bits(32);   // Upper bits must be ignored
            do_request("random", op, f3, addr, rand_bits(32));
        end

        for (int n = 0; n < FAULT_OPS; n++)
        begin
            do
            begin
                if (rand_bits(1))
                    op = rand_bits(1) ? rv_lsu_isa_pkg::OPC_STORE : rv_lsu_isa_pkg::OPC_LOAD;
                else
                    op = rand_bits(7);
                f3 = rand_bits(3);
            end
            while (instr_supported(op, f3));
            addr = rand_bits(32);
            do_request("fault", op, f3, addr, rand_bits(32));
            do_request("after fault LW", rv_lsu_isa_pkg::OPC_LOAD, rv_lsu_isa_pkg::F3_W, addr,
                       32'd0);
        end

        busy_overlap_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
